// ==== rtl/hdg_pkg.sv ====
// widths and word types shared by the signal-generator core
// all memory and register payloads are 32-bit words with byte selects
// the control port uses byte addresses, one word per 4 bytes

`default_nettype none

package hdg_pkg;

    // test pattern
    localparam int DAC_W  = 16;
    localparam int SYNC_W = 8;

    // memory and register words
    localparam int RAM_DATA_W = 32;
    localparam int RAM_SEL_W  = 4;

    // control register space
    localparam int CTRL_ADDR_W = 8;
    localparam int CTRL_WORDS  = 64;

    // read path staging depth
    localparam int RD_FIFO_DEPTH = 2;

    typedef logic [DAC_W-1:0]       dac_word_t;
    typedef logic [RAM_DATA_W-1:0]  ram_word_t;
    typedef logic [RAM_SEL_W-1:0]   ram_sel_t;
    typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;

endpackage

`default_nettype wire

// ==== rtl/pattern_gen.sv ====
// free-running 16-bit test pattern, counting from zero after reset
// DAC port 1 trails the digital output by one cycle
// DAC port 2 carries the two's-complement negative of port 1

`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
    input  wire                        clk_250mhz,
    input  wire                        arst_n_i,
    output hdg_pkg::dac_word_t         dout_o,
    output logic [hdg_pkg::SYNC_W-1:0] sync_dac_o,
    output hdg_pkg::dac_word_t         dac_p1_d_o,
    output hdg_pkg::dac_word_t         dac_p2_d_o
);

    import hdg_pkg::*;

    dac_word_t count_q;

    // pattern counter, wraps at 2^16
    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign dout_o     = count_q;
    assign sync_dac_o = count_q[DAC_W-1 -: SYNC_W];

    // main DAC ports, both loaded on the same edge
    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dac_p1_d_o <= '0;
            dac_p2_d_o <= '0;
        end else begin
            dac_p1_d_o <= count_q;
            dac_p2_d_o <= -count_q;
        end
    end

    // port pair stays complementary on every cycle
    a_p2_neg_p1: assert property (@(posedge clk_250mhz) disable iff (!arst_n_i)
        dac_p2_d_o == dac_word_t'(-dac_p1_d_o))
        else $error("pattern_gen: port 2 is not the negative of port 1");

endmodule

`default_nettype wire

// ==== rtl/mcb_rd_fifo.sv ====
// register FIFO staging one memory read port, DEPTH must be 2 or more
// a word popped upstream shows at fifo_data_o from the next cycle
// the consumer may only pop while fifo_empty_o is low
// upstream is not popped for the first cycle after reset

`timescale 1ns/1ps
`default_nettype none

module mcb_rd_fifo #(
    parameter int DEPTH = hdg_pkg::RD_FIFO_DEPTH
) (
    input  wire                     clk_250mhz,
    input  wire                     arst_n_i,
    input  wire                     rd_empty_i,
    input  wire hdg_pkg::ram_word_t rd_data_i,
    output logic                    rd_en_o,
    input  wire                     fifo_rd_en_i,
    output hdg_pkg::ram_word_t      fifo_data_o,
    output logic                    fifo_empty_o
);

    import hdg_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ram_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             space_q;
    logic             pop;

    // pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // occupancy and upstream pop
    ////////////////////////////////////////////////////////////

    // space_q tracks count_q < DEPTH, registered to keep the pop decision short
    assign rd_en_o = space_q & ~rd_empty_i;
    assign pop     = fifo_rd_en_i & ~fifo_empty_o;
    assign count_d = count_q + CNT_W'(rd_en_o) - CNT_W'(pop);

    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            space_q  <= 1'b0;
        end else begin
            if (rd_en_o) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_d;
            space_q <= (count_d != CNT_W'(DEPTH));
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_250mhz) begin
        if (rd_en_o) begin
            mem[wr_ptr_q] <= rd_data_i;
        end
    end

    // oldest word
    assign fifo_data_o  = mem[rd_ptr_q];
    assign fifo_empty_o = (count_q == '0);

    a_no_pop_empty: assert property (@(posedge clk_250mhz) disable iff (!arst_n_i)
        fifo_rd_en_i |-> !fifo_empty_o)
        else $error("mcb_rd_fifo: consumer pop while empty");

    a_count_max: assert property (@(posedge clk_250mhz) disable iff (!arst_n_i)
        count_q <= CNT_W'(DEPTH))
        else $error("mcb_rd_fifo: occupancy above DEPTH");

endmodule

`default_nettype wire

// ==== rtl/ctrl_reg_ram.sv ====
// 64-word control register RAM with byte-lane writes
// the master holds strobe, address and data until the acknowledge
// acknowledge follows one cycle after the strobe is taken
// contents are undefined until written

`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_ram (
    input  wire                      clk_250mhz,
    input  wire                      arst_n_i,
    input  wire                      ctrl_stb_i,
    input  wire                      ctrl_we_i,
    input  wire hdg_pkg::ctrl_addr_t ctrl_adr_i,
    input  wire hdg_pkg::ram_sel_t   ctrl_sel_i,
    input  wire hdg_pkg::ram_word_t  ctrl_dat_i,
    output hdg_pkg::ram_word_t       ctrl_dat_o,
    output logic                     ctrl_ack_o
);

    import hdg_pkg::*;

    localparam int IDX_W = $clog2(CTRL_WORDS);

    ram_word_t        mem [CTRL_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             accept;

    // byte address to word index
    assign word_idx = ctrl_adr_i[IDX_W+1:2];

    // a held strobe is taken once, not again while acked
    assign accept = ctrl_stb_i & ~ctrl_ack_o;

    always_ff @(posedge clk_250mhz) begin
        if (accept) begin
            ctrl_dat_o <= mem[word_idx];
            if (ctrl_we_i) begin
                for (int b = 0; b < RAM_SEL_W; b++) begin
                    if (ctrl_sel_i[b]) begin
                        mem[word_idx][8*b +: 8] <= ctrl_dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_ack_o <= 1'b0;
        end else begin
            ctrl_ack_o <= accept;
        end
    end

    a_ack_pulse: assert property (@(posedge clk_250mhz) disable iff (!arst_n_i)
        ctrl_ack_o |=> !ctrl_ack_o)
        else $error("ctrl_reg_ram: acknowledge held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/hdg_core.sv ====
// signal-generator core on a single 250 MHz clock domain
// test pattern outputs, staged first read port of each RAM and the control RAM
// FIFO read sides and the control port go straight to the top-level ports

`timescale 1ns/1ps
`default_nettype none

module hdg_core (
    input  wire                        clk_250mhz,
    input  wire                        arst_n_i,

    // digital output, sync DAC and main DAC
    output hdg_pkg::dac_word_t         dout_o,
    output logic [hdg_pkg::SYNC_W-1:0] sync_dac_o,
    output hdg_pkg::dac_word_t         dac_p1_d_o,
    output hdg_pkg::dac_word_t         dac_p2_d_o,

    // ram 1 read port and its staged side
    input  wire                        ram1_rd_empty_i,
    input  wire hdg_pkg::ram_word_t    ram1_rd_data_i,
    output logic                       ram1_rd_en_o,
    input  wire                        ram1_fifo_rd_en_i,
    output hdg_pkg::ram_word_t         ram1_fifo_data_o,
    output logic                       ram1_fifo_empty_o,

    // ram 2 read port and its staged side
    input  wire                        ram2_rd_empty_i,
    input  wire hdg_pkg::ram_word_t    ram2_rd_data_i,
    output logic                       ram2_rd_en_o,
    input  wire                        ram2_fifo_rd_en_i,
    output hdg_pkg::ram_word_t         ram2_fifo_data_o,
    output logic                       ram2_fifo_empty_o,

    // control register port
    input  wire                        ctrl_stb_i,
    input  wire                        ctrl_we_i,
    input  wire hdg_pkg::ctrl_addr_t   ctrl_adr_i,
    input  wire hdg_pkg::ram_sel_t     ctrl_sel_i,
    input  wire hdg_pkg::ram_word_t    ctrl_dat_i,
    output hdg_pkg::ram_word_t         ctrl_dat_o,
    output logic                       ctrl_ack_o
);

    import hdg_pkg::*;

    ////////////////////////////////////////////////////////////
    // test pattern
    ////////////////////////////////////////////////////////////

    pattern_gen i_pattern_gen (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .dout_o     (dout_o),
        .sync_dac_o (sync_dac_o),
        .dac_p1_d_o (dac_p1_d_o),
        .dac_p2_d_o (dac_p2_d_o)
    );

    ////////////////////////////////////////////////////////////
    // read path staging, first read port of each RAM
    ////////////////////////////////////////////////////////////

    mcb_rd_fifo #(
        .DEPTH (RD_FIFO_DEPTH)
    ) ram1_rd_fifo (
        .clk_250mhz   (clk_250mhz),
        .arst_n_i     (arst_n_i),
        .rd_empty_i   (ram1_rd_empty_i),
        .rd_data_i    (ram1_rd_data_i),
        .rd_en_o      (ram1_rd_en_o),
        .fifo_rd_en_i (ram1_fifo_rd_en_i),
        .fifo_data_o  (ram1_fifo_data_o),
        .fifo_empty_o (ram1_fifo_empty_o)
    );

    mcb_rd_fifo #(
        .DEPTH (RD_FIFO_DEPTH)
    ) ram2_rd_fifo (
        .clk_250mhz   (clk_250mhz),
        .arst_n_i     (arst_n_i),
        .rd_empty_i   (ram2_rd_empty_i),
        .rd_data_i    (ram2_rd_data_i),
        .rd_en_o      (ram2_rd_en_o),
        .fifo_rd_en_i (ram2_fifo_rd_en_i),
        .fifo_data_o  (ram2_fifo_data_o),
        .fifo_empty_o (ram2_fifo_empty_o)
    );

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////

    ctrl_reg_ram i_ctrl_reg_ram (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .ctrl_stb_i (ctrl_stb_i),
        .ctrl_we_i  (ctrl_we_i),
        .ctrl_adr_i (ctrl_adr_i),
        .ctrl_sel_i (ctrl_sel_i),
        .ctrl_dat_i (ctrl_dat_i),
        .ctrl_dat_o (ctrl_dat_o),
        .ctrl_ack_o (ctrl_ack_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_hdg_core.sv ====
// random traffic on both read stagings and the control port with the pattern checked each cycle
// inputs change 0.5 ns after the rising edge and outputs are checked at the falling edge
// upstream holds its word until popped and consumers only read while not empty
// the run stops at the first error

`timescale 1ns/1ps
`default_nettype none

module tb_hdg_core;

    import hdg_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int STIM_CYCLES   = 2000;
    localparam int TOTAL_OPS     = CTRL_WORDS + 300;
    localparam int EXP_SIZE      = 4096;
    localparam int WATCHDOG_NS   = 20 * (RESET_CYCLES + STIM_CYCLES) * CLK_PERIOD_NS;

    logic                clk_250mhz;
    logic                arst_n_i;
    dac_word_t           dout_o;
    logic [SYNC_W-1:0]   sync_dac_o;
    dac_word_t           dac_p1_d_o;
    dac_word_t           dac_p2_d_o;
    logic                ram1_rd_empty_i;
    ram_word_t           ram1_rd_data_i;
    logic                ram1_rd_en_o;
    logic                ram1_fifo_rd_en_i;
    ram_word_t           ram1_fifo_data_o;
    logic                ram1_fifo_empty_o;
    logic                ram2_rd_empty_i;
    ram_word_t           ram2_rd_data_i;
    logic                ram2_rd_en_o;
    logic                ram2_fifo_rd_en_i;
    ram_word_t           ram2_fifo_data_o;
    logic                ram2_fifo_empty_o;
    logic                ctrl_stb_i;
    logic                ctrl_we_i;
    ctrl_addr_t          ctrl_adr_i;
    ram_sel_t            ctrl_sel_i;
    ram_word_t           ctrl_dat_i;
    ram_word_t           ctrl_dat_o;
    logic                ctrl_ack_o;

    // reference models
    logic [31:0] lfsr_q = 32'hf241_b826;
    ram_word_t   up_word [2];
    int          level [2];
    int          idle_cnt [2];
    ram_word_t   exp_mem [2][EXP_SIZE];
    int          exp_wr [2];
    int          exp_rd [2];
    ram_word_t   ctrl_model [CTRL_WORDS];
    ram_word_t   ctrl_exp;
    logic        ctrl_busy;
    logic        ctrl_rd;
    int          ctrl_age;
    int          ops_started;
    int          ops_done;
    dac_word_t   exp_count;
    dac_word_t   exp_p1;
    logic        first_sample;
    logic        draining;
    int          fail_count;

    hdg_core i_dut (
        .clk_250mhz        (clk_250mhz),
        .arst_n_i          (arst_n_i),
        .dout_o            (dout_o),
        .sync_dac_o        (sync_dac_o),
        .dac_p1_d_o        (dac_p1_d_o),
        .dac_p2_d_o        (dac_p2_d_o),
        .ram1_rd_empty_i   (ram1_rd_empty_i),
        .ram1_rd_data_i    (ram1_rd_data_i),
        .ram1_rd_en_o      (ram1_rd_en_o),
        .ram1_fifo_rd_en_i (ram1_fifo_rd_en_i),
        .ram1_fifo_data_o  (ram1_fifo_data_o),
        .ram1_fifo_empty_o (ram1_fifo_empty_o),
        .ram2_rd_empty_i   (ram2_rd_empty_i),
        .ram2_rd_data_i    (ram2_rd_data_i),
        .ram2_rd_en_o      (ram2_rd_en_o),
        .ram2_fifo_rd_en_i (ram2_fifo_rd_en_i),
        .ram2_fifo_data_o  (ram2_fifo_data_o),
        .ram2_fifo_empty_o (ram2_fifo_empty_o),
        .ctrl_stb_i        (ctrl_stb_i),
        .ctrl_we_i         (ctrl_we_i),
        .ctrl_adr_i        (ctrl_adr_i),
        .ctrl_sel_i        (ctrl_sel_i),
        .ctrl_dat_i        (ctrl_dat_i),
        .ctrl_dat_o        (ctrl_dat_o),
        .ctrl_ack_o        (ctrl_ack_o)
    );

    initial clk_250mhz = 1'b0;
    always #(CLK_PERIOD_NS / 2) clk_250mhz = ~clk_250mhz;

    ////////////////////////////////////////////////////////////
    // random numbers and error reporting
    ////////////////////////////////////////////////////////////

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // only selected byte lanes take the new data
    function automatic ram_word_t merge_bytes(input ram_word_t old_w, input ram_word_t new_w,
                                              input ram_sel_t sel);
        ram_word_t r;
        r = old_w;
        for (int b = 0; b < RAM_SEL_W; b++) begin
            if (sel[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic stop_on_error();
        fail_count++;
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR time=%0t %s", $time, what);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic start_ctrl_op();
        ctrl_addr_t adr;
        if (ops_started < CTRL_WORDS) begin
            // fill every word once before the random mix
            adr = ctrl_addr_t'(ops_started << 2);
            ctrl_we_i  = 1'b1;
            ctrl_sel_i = '1;
        end else begin
            adr = rand_bits(CTRL_ADDR_W);
            ctrl_we_i  = rand_bits(1);
            ctrl_sel_i = rand_bits(RAM_SEL_W);
        end
        ctrl_adr_i = adr;
        ctrl_dat_i = rand_bits(RAM_DATA_W);
        ctrl_rd    = !ctrl_we_i;
        ctrl_exp   = ctrl_model[adr[7:2]];
        if (ctrl_we_i) begin
            ctrl_model[adr[7:2]] = merge_bytes(ctrl_exp, ctrl_dat_i, ctrl_sel_i);
        end
        ctrl_busy = 1'b1;
        ctrl_age  = 0;
        ops_started++;
    endtask

    task automatic drive_cycle();
        logic [1:0] up_empty;
        logic [1:0] cons_rd;
        logic [1:0] empty_now;
        empty_now = {ram2_fifo_empty_o, ram1_fifo_empty_o};
        for (int ch = 0; ch < 2; ch++) begin
            up_empty[ch] = draining ? 1'b1 : (rand_bits(2) == 0);
            if (draining) begin
                cons_rd[ch] = !empty_now[ch];
            end else if (idle_cnt[ch] > 0) begin
                idle_cnt[ch]--;
                cons_rd[ch] = 1'b0;
            end else if (rand_bits(4) == 0) begin
                // idle stretch to push the FIFO into back-pressure
                idle_cnt[ch] = rand_bits(4);
                cons_rd[ch] = 1'b0;
            end else begin
                cons_rd[ch] = (rand_bits(1) == 1) && !empty_now[ch];
            end
        end
        ram1_rd_empty_i   = up_empty[0];
        ram1_rd_data_i    = up_word[0];
        ram1_fifo_rd_en_i = cons_rd[0];
        ram2_rd_empty_i   = up_empty[1];
        ram2_rd_data_i    = up_word[1];
        ram2_fifo_rd_en_i = cons_rd[1];
        if (!ctrl_busy && ops_started < TOTAL_OPS && rand_bits(2) != 0) begin
            start_ctrl_op();
        end
        ctrl_stb_i = ctrl_busy;
    endtask

    ////////////////////////////////////////////////////////////
    // checks at the falling edge
    ////////////////////////////////////////////////////////////

    task automatic check_channel(input int ch, input logic up_empty, input logic pop_up,
                                 input ram_word_t up_data, input logic cons_rd,
                                 input logic empty, input ram_word_t data);
        string pfx;
        pfx = (ch == 0) ? "ram1" : "ram2";
        check_true(!(pop_up && up_empty), $sformatf("%s_rd_en_o high while upstream empty", pfx));
        check_value($sformatf("%s_fifo_empty_o", pfx), empty, level[ch] == 0);
        if (level[ch] >= RD_FIFO_DEPTH) begin
            check_true(!pop_up, $sformatf("%s popped upstream while FIFO full", pfx));
        end
        if (cons_rd && !empty) begin
            check_value($sformatf("%s_fifo_data_o", pfx), data,
                        exp_mem[ch][exp_rd[ch] % EXP_SIZE]);
            exp_rd[ch]++;
            level[ch]--;
        end
        if (pop_up) begin
            exp_mem[ch][exp_wr[ch] % EXP_SIZE] = up_data;
            exp_wr[ch]++;
            level[ch]++;
            up_word[ch] = rand_bits(RAM_DATA_W);
        end
    endtask

    task automatic check_reset_state();
        check_value("dout_o", dout_o, 0);
        check_value("sync_dac_o", sync_dac_o, 0);
        check_value("dac_p1_d_o", dac_p1_d_o, 0);
        check_value("dac_p2_d_o", dac_p2_d_o, 0);
        check_value("ram1_rd_en_o", ram1_rd_en_o, 0);
        check_value("ram2_rd_en_o", ram2_rd_en_o, 0);
        check_value("ram1_fifo_empty_o", ram1_fifo_empty_o, 1);
        check_value("ram2_fifo_empty_o", ram2_fifo_empty_o, 1);
        check_value("ctrl_ack_o", ctrl_ack_o, 0);
    endtask

    task automatic check_cycle();
        dac_word_t neg_p1;
        if (first_sample) begin
            check_reset_state();
            first_sample = 1'b0;
        end
        neg_p1 = dac_word_t'(0) - exp_p1;
        check_value("dout_o", dout_o, exp_count);
        check_value("sync_dac_o", sync_dac_o, exp_count >> (DAC_W - SYNC_W));
        check_value("dac_p1_d_o", dac_p1_d_o, exp_p1);
        check_value("dac_p2_d_o", dac_p2_d_o, neg_p1);
        exp_p1 = exp_count;
        exp_count++;
        check_channel(0, ram1_rd_empty_i, ram1_rd_en_o, ram1_rd_data_i,
                      ram1_fifo_rd_en_i, ram1_fifo_empty_o, ram1_fifo_data_o);
        check_channel(1, ram2_rd_empty_i, ram2_rd_en_o, ram2_rd_data_i,
                      ram2_fifo_rd_en_i, ram2_fifo_empty_o, ram2_fifo_data_o);
        // strobe seen on the next edge and acknowledged in the cycle after
        if (ctrl_busy) begin
            ctrl_age++;
            if (ctrl_age == 1) begin
                check_true(!ctrl_ack_o, "control acknowledge came in the strobe cycle");
            end else begin
                check_true(ctrl_ack_o, "control acknowledge missing 2 cycles after strobe");
                if (ctrl_rd) begin
                    check_value("ctrl_dat_o", ctrl_dat_o, ctrl_exp);
                end
                ctrl_busy = 1'b0;
                ops_done++;
            end
        end else begin
            check_true(!ctrl_ack_o, "control acknowledge without a strobe");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n_i          = 1'b0;
        ram1_rd_empty_i   = 1'b1;
        ram1_rd_data_i    = '0;
        ram1_fifo_rd_en_i = 1'b0;
        ram2_rd_empty_i   = 1'b1;
        ram2_rd_data_i    = '0;
        ram2_fifo_rd_en_i = 1'b0;
        ctrl_stb_i        = 1'b0;
        ctrl_we_i         = 1'b0;
        ctrl_adr_i        = '0;
        ctrl_sel_i        = '0;
        ctrl_dat_i        = '0;
        ctrl_busy    = 1'b0;
        ops_started  = 0;
        ops_done     = 0;
        exp_count    = '0;
        exp_p1       = '0;
        draining     = 1'b0;
        fail_count   = 0;
        for (int ch = 0; ch < 2; ch++) begin
            level[ch]    = 0;
            idle_cnt[ch] = 0;
            exp_wr[ch]   = 0;
            exp_rd[ch]   = 0;
            up_word[ch]  = rand_bits(RAM_DATA_W);
        end
        repeat (RESET_CYCLES) begin
            @(negedge clk_250mhz);
            check_reset_state();
        end
        @(posedge clk_250mhz);
        #0.5;
        arst_n_i     = 1'b1;
        first_sample = 1'b1;
        drive_cycle();
        @(negedge clk_250mhz);
        check_cycle();
        for (int cyc = 1; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clk_250mhz);
            #0.5;
            drive_cycle();
            @(negedge clk_250mhz);
            check_cycle();
        end
        // upstream runs dry while consumers and the control port finish
        draining = 1'b1;
        while (ops_done < TOTAL_OPS || level[0] != 0 || level[1] != 0) begin
            @(posedge clk_250mhz);
            #0.5;
            drive_cycle();
            @(negedge clk_250mhz);
            check_cycle();
        end
        for (int ch = 0; ch < 2; ch++) begin
            check_true(exp_wr[ch] > 0, $sformatf("no word passed through channel %0d", ch + 1));
        end
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("ERROR time=%0t run did not finish before the watchdog expired", $time);
        $display("Verification failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/hdg_pkg.sv
rtl/pattern_gen.sv
rtl/mcb_rd_fifo.sv
rtl/ctrl_reg_ram.sv
rtl/hdg_core.sv
test/tb_hdg_core.sv
